// ==== bank_pwr_fsm.sv ====
/* power sequencer for one memory bank; orders switch, isolation, reset,
   clock gate and retention on requests from the register block */
`timescale 1ns/10ps

module bank_pwr_fsm (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     on_req_i,
  input  logic                     ret_req_i,
  input  logic                     ack_i,
  output mem_pwr_pkg::bank_ctrl_t  ctrl_o,
  output mem_pwr_pkg::bank_state_e state_o,
  output logic                     done_o
);

  mem_pwr_pkg::seq_state_e state_q;
  mem_pwr_pkg::seq_state_e state_d;
  mem_pwr_pkg::settle_cnt_t settle_q;
  mem_pwr_pkg::bank_ctrl_t ctrl_d;
  mem_pwr_pkg::bank_ctrl_t ctrl_q;
  logic settled;
  logic done_d;
  logic done_q;

  assign settled = (settle_q == mem_pwr_pkg::settle_cnt_t'(mem_pwr_pkg::ISO_SETTLE - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_pwr_pkg::ST_OFF:
        if (on_req_i)
          state_d = mem_pwr_pkg::ST_SW_ON;
      // switch closing takes as long as it takes
      mem_pwr_pkg::ST_SW_ON:
        if (ack_i)
          state_d = mem_pwr_pkg::ST_ISO_REL;
      mem_pwr_pkg::ST_ISO_REL:
        if (settled)
          state_d = mem_pwr_pkg::ST_ON;
      mem_pwr_pkg::ST_ON:
        if (!on_req_i)
          state_d = mem_pwr_pkg::ST_GATE;
      mem_pwr_pkg::ST_GATE:
        state_d = ret_req_i ? mem_pwr_pkg::ST_RET : mem_pwr_pkg::ST_SW_OFF;
      mem_pwr_pkg::ST_SW_OFF:
        if (!ack_i)
          state_d = mem_pwr_pkg::ST_OFF;
      mem_pwr_pkg::ST_RET: begin
        if (on_req_i) begin
          state_d = mem_pwr_pkg::ST_ISO_REL;
        end else if (!ret_req_i) begin
          state_d = mem_pwr_pkg::ST_SW_OFF;
        end
      end
      default: state_d = mem_pwr_pkg::ST_OFF;
    endcase
  end

  // outputs follow the next state, so they line up with state_q
  always_comb begin
    ctrl_d = mem_pwr_pkg::CTRL_OFF;
    case (state_d)
      mem_pwr_pkg::ST_SW_ON: ctrl_d.pwr_sw = 1'b1;
      mem_pwr_pkg::ST_ISO_REL: begin
        ctrl_d.pwr_sw = 1'b1;
        ctrl_d.iso = 1'b0;
      end
      mem_pwr_pkg::ST_ON: begin
        ctrl_d.pwr_sw = 1'b1;
        ctrl_d.iso = 1'b0;
        ctrl_d.rst = 1'b0;
        ctrl_d.clk_en = 1'b1;
      end
      mem_pwr_pkg::ST_GATE: ctrl_d.pwr_sw = 1'b1;
      mem_pwr_pkg::ST_RET: begin
        ctrl_d.pwr_sw = 1'b1;
        ctrl_d.retentive = 1'b1;
      end
      default: ctrl_d = mem_pwr_pkg::CTRL_OFF;
    endcase
  end

  assign done_d = (state_d != state_q) &&
                  (state_d inside {mem_pwr_pkg::ST_ON, mem_pwr_pkg::ST_OFF, mem_pwr_pkg::ST_RET});

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= mem_pwr_pkg::ST_OFF;
      ctrl_q <= mem_pwr_pkg::CTRL_OFF;
      done_q <= 1'b0;
      settle_q <= '0;
    end else begin
      state_q <= state_d;
      ctrl_q <= ctrl_d;
      done_q <= done_d;
      // counts only while isolation is released and reset still held
      if (state_q == mem_pwr_pkg::ST_ISO_REL) begin
        settle_q <= settle_q + 1'b1;
      end else begin
        settle_q <= '0;
      end
    end
  end

  always_comb begin
    case (state_q)
      mem_pwr_pkg::ST_OFF: state_o = mem_pwr_pkg::BANK_OFF;
      mem_pwr_pkg::ST_ON: state_o = mem_pwr_pkg::BANK_ON;
      mem_pwr_pkg::ST_RET: state_o = mem_pwr_pkg::BANK_RET;
      default: state_o = mem_pwr_pkg::BANK_BUSY;
    endcase
  end

  assign ctrl_o = ctrl_q;
  assign done_o = done_q;

endmodule

// ==== mem_pwr_chk.sv ====
/* concurrent checks on bank power sequencing and on the AXI4-Lite
   response channels, bound into the power manager top level */
`timescale 1ns/10ps

module mem_pwr_chk (
  input logic                                                 clk_i,
  input logic                                                 rst_i,
  input mem_pwr_pkg::axil_req_t                               axil_req_i,
  input mem_pwr_pkg::axil_rsp_t                               axil_rsp_i,
  input mem_pwr_pkg::bank_mask_t                              bank_ack_i,
  input mem_pwr_pkg::bank_ctrl_t [mem_pwr_pkg::NUM_BANKS-1:0] bank_ctrl_i
);

  int err_cnt = 0;

  for (genvar b = 0; b < mem_pwr_pkg::NUM_BANKS; b++) begin : gen_bank_chk
    iso_needs_ack: assert property (@(posedge clk_i) disable iff (rst_i)
      !bank_ctrl_i[b].iso |-> bank_ack_i[b])
      else begin
        $error("bank %0d isolation released while switch ack is low", b);
        err_cnt++;
      end

    rst_needs_iso_off: assert property (@(posedge clk_i) disable iff (rst_i)
      !bank_ctrl_i[b].rst |-> !bank_ctrl_i[b].iso)
      else begin
        $error("bank %0d reset released while isolation is high", b);
        err_cnt++;
      end

    clk_needs_rst_off: assert property (@(posedge clk_i) disable iff (rst_i)
      bank_ctrl_i[b].clk_en |-> !bank_ctrl_i[b].rst)
      else begin
        $error("bank %0d clock enabled while reset is high", b);
        err_cnt++;
      end

    // switch may only open on a gated, isolated bank
    sw_off_safe: assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(bank_ctrl_i[b].pwr_sw) |-> !$past(bank_ctrl_i[b].clk_en) && $past(bank_ctrl_i[b].iso))
      else begin
        $error("bank %0d switch opened while clocked or not isolated", b);
        err_cnt++;
      end

    ret_outputs: assert property (@(posedge clk_i) disable iff (rst_i)
      bank_ctrl_i[b].retentive |->
        bank_ctrl_i[b].pwr_sw && bank_ctrl_i[b].iso && !bank_ctrl_i[b].clk_en)
      else begin
        $error("bank %0d retention with wrong switch, isolation or clock", b);
        err_cnt++;
      end
  end

  bresp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid && $stable(axil_rsp_i.bresp))
    else begin
      $error("write response dropped or changed before bready");
      err_cnt++;
    end

  rresp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata))
    else begin
      $error("read response dropped or changed before rready");
      err_cnt++;
    end

endmodule

bind mem_pwr_top mem_pwr_chk u_chk (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .axil_req_i  (axil_req_i),
  .axil_rsp_i  (axil_rsp_o),
  .bank_ack_i  (bank_ack_i),
  .bank_ctrl_i (bank_ctrl_o)
);

// ==== mem_pwr_pkg.sv ====
/* shared widths, register map, bus and control types of the memory bank
   power controller, referenced everywhere by scoped name */
package mem_pwr_pkg;

  localparam int NUM_BANKS = 4;
  // cycles between isolation release and reset release
  localparam int ISO_SETTLE = 2;
  localparam int SETTLE_W = $clog2(ISO_SETTLE + 1);

  localparam int ADDR_W = 5;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0] reg_data_t;
  typedef logic [DATA_W/8-1:0] reg_strb_t;
  typedef logic [1:0] axi_resp_t;
  typedef logic [NUM_BANKS-1:0] bank_mask_t;
  typedef logic [SETTLE_W-1:0] settle_cnt_t;

  // register map
  localparam reg_addr_t REG_POWER_ON = 5'h00;
  localparam reg_addr_t REG_RETENTIVE = 5'h04;
  localparam reg_addr_t REG_STATE = 5'h08;
  localparam reg_addr_t REG_INTR_PENDING = 5'h0C;
  localparam reg_addr_t REG_INTR_ENABLE = 5'h10;

  localparam axi_resp_t RESP_OKAY = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // state of one bank as seen through REG_STATE
  typedef enum logic [1:0] {
    BANK_OFF = 2'd0,
    BANK_RET = 2'd1,
    BANK_ON = 2'd2,
    BANK_BUSY = 2'd3
  } bank_state_e;

  typedef enum logic [2:0] {
    ST_OFF,
    ST_SW_ON,
    ST_ISO_REL,
    ST_ON,
    ST_GATE,
    ST_SW_OFF,
    ST_RET
  } seq_state_e;

  typedef struct packed {
    logic pwr_sw;
    logic iso;
    logic rst;
    logic clk_en;
    logic retentive;
  } bank_ctrl_t;

  // switch open, isolated, held in reset
  localparam bank_ctrl_t CTRL_OFF = '{
    pwr_sw: 1'b0,
    iso: 1'b1,
    rst: 1'b1,
    clk_en: 1'b0,
    retentive: 1'b0
  };

  typedef struct packed {
    logic awvalid;
    reg_addr_t awaddr;
    logic wvalid;
    reg_data_t wdata;
    reg_strb_t wstrb;
    logic bready;
    logic arvalid;
    reg_addr_t araddr;
    logic rready;
  } axil_req_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    axi_resp_t bresp;
    logic arready;
    logic rvalid;
    reg_data_t rdata;
    axi_resp_t rresp;
  } axil_rsp_t;

endpackage

// ==== mem_pwr_regs.sv ====
/* AXI4-Lite register block of the power manager; holds the power-on,
   retention and interrupt-enable masks and returns bank state and pending */
`timescale 1ns/10ps

module mem_pwr_regs (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  mem_pwr_pkg::axil_req_t                                axil_req_i,
  output mem_pwr_pkg::axil_rsp_t                                axil_rsp_o,
  input  mem_pwr_pkg::bank_state_e [mem_pwr_pkg::NUM_BANKS-1:0] state_i,
  input  mem_pwr_pkg::bank_mask_t                               pending_i,
  output mem_pwr_pkg::bank_mask_t                               on_req_o,
  output mem_pwr_pkg::bank_mask_t                               ret_req_o,
  output mem_pwr_pkg::bank_mask_t                               intr_enable_o,
  output mem_pwr_pkg::bank_mask_t                               pending_clr_o
);

  logic wr_take;
  logic rd_take;
  logic bvalid_q;
  logic rvalid_q;
  mem_pwr_pkg::axi_resp_t wr_resp;
  mem_pwr_pkg::axi_resp_t rd_resp;
  mem_pwr_pkg::axi_resp_t bresp_q;
  mem_pwr_pkg::axi_resp_t rresp_q;
  mem_pwr_pkg::reg_data_t rd_data;
  mem_pwr_pkg::reg_data_t rdata_q;
  mem_pwr_pkg::bank_mask_t wr_bits;
  mem_pwr_pkg::bank_mask_t on_req_q;
  mem_pwr_pkg::bank_mask_t ret_req_q;
  mem_pwr_pkg::bank_mask_t intr_en_q;
  mem_pwr_pkg::bank_mask_t clr_q;

  // one response in flight per channel
  assign wr_take = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
  assign rd_take = axil_req_i.arvalid && !rvalid_q;
  assign wr_bits = axil_req_i.wdata[mem_pwr_pkg::NUM_BANKS-1:0];

  always_comb begin
    wr_resp = mem_pwr_pkg::RESP_OKAY;
    case (axil_req_i.awaddr)
      mem_pwr_pkg::REG_POWER_ON,
      mem_pwr_pkg::REG_RETENTIVE,
      mem_pwr_pkg::REG_STATE,
      mem_pwr_pkg::REG_INTR_PENDING,
      mem_pwr_pkg::REG_INTR_ENABLE: wr_resp = mem_pwr_pkg::RESP_OKAY;
      default: wr_resp = mem_pwr_pkg::RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = mem_pwr_pkg::RESP_OKAY;
    case (axil_req_i.araddr)
      mem_pwr_pkg::REG_POWER_ON: rd_data = mem_pwr_pkg::reg_data_t'(on_req_q);
      mem_pwr_pkg::REG_RETENTIVE: rd_data = mem_pwr_pkg::reg_data_t'(ret_req_q);
      // two bits per bank, bank 0 lowest
      mem_pwr_pkg::REG_STATE: rd_data = mem_pwr_pkg::reg_data_t'(state_i);
      mem_pwr_pkg::REG_INTR_PENDING: rd_data = mem_pwr_pkg::reg_data_t'(pending_i);
      mem_pwr_pkg::REG_INTR_ENABLE: rd_data = mem_pwr_pkg::reg_data_t'(intr_en_q);
      default: rd_resp = mem_pwr_pkg::RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      on_req_q <= '0;
      ret_req_q <= '0;
      intr_en_q <= '0;
      clr_q <= '0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      clr_q <= '0;
      if (wr_take) begin
        case (axil_req_i.awaddr)
          mem_pwr_pkg::REG_POWER_ON: on_req_q <= wr_bits;
          mem_pwr_pkg::REG_RETENTIVE: ret_req_q <= wr_bits;
          mem_pwr_pkg::REG_INTR_ENABLE: intr_en_q <= wr_bits;
          // write one to clear, pulse lasts a single cycle
          mem_pwr_pkg::REG_INTR_PENDING: clr_q <= wr_bits;
          default: ;
        endcase
      end
      if (wr_take) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_take) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // response payload, held while the valid waits
  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      bresp_q <= wr_resp;
    end
    if (rd_take) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp_o.awready = wr_take;
    axil_rsp_o.wready = wr_take;
    axil_rsp_o.bvalid = bvalid_q;
    axil_rsp_o.bresp = bresp_q;
    axil_rsp_o.arready = rd_take;
    axil_rsp_o.rvalid = rvalid_q;
    axil_rsp_o.rdata = rdata_q;
    axil_rsp_o.rresp = rresp_q;
  end

  assign on_req_o = on_req_q;
  assign ret_req_o = ret_req_q;
  assign intr_enable_o = intr_en_q;
  assign pending_clr_o = clr_q;

endmodule

// ==== mem_pwr_top.sv ====
/* memory bank power manager: register block, one sequencer per bank
   and the status collector that drives the interrupt */
`timescale 1ns/10ps

module mem_pwr_top (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  mem_pwr_pkg::axil_req_t                               axil_req_i,
  output mem_pwr_pkg::axil_rsp_t                               axil_rsp_o,
  input  mem_pwr_pkg::bank_mask_t                              bank_ack_i,
  output mem_pwr_pkg::bank_ctrl_t [mem_pwr_pkg::NUM_BANKS-1:0] bank_ctrl_o,
  output logic                                                 irq_o
);

  mem_pwr_pkg::bank_state_e [mem_pwr_pkg::NUM_BANKS-1:0] bank_state;
  mem_pwr_pkg::bank_mask_t done;
  mem_pwr_pkg::bank_mask_t pending;
  mem_pwr_pkg::bank_mask_t pending_clr;
  mem_pwr_pkg::bank_mask_t on_req;
  mem_pwr_pkg::bank_mask_t ret_req;
  mem_pwr_pkg::bank_mask_t intr_enable;

  mem_pwr_regs u_regs (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .axil_req_i    (axil_req_i),
    .axil_rsp_o    (axil_rsp_o),
    .state_i       (bank_state),
    .pending_i     (pending),
    .on_req_o      (on_req),
    .ret_req_o     (ret_req),
    .intr_enable_o (intr_enable),
    .pending_clr_o (pending_clr)
  );

  for (genvar i = 0; i < mem_pwr_pkg::NUM_BANKS; i++) begin : gen_bank
    bank_pwr_fsm u_fsm (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .on_req_i  (on_req[i]),
      .ret_req_i (ret_req[i]),
      .ack_i     (bank_ack_i[i]),
      .ctrl_o    (bank_ctrl_o[i]),
      .state_o   (bank_state[i]),
      .done_o    (done[i])
    );
  end

  pwr_status_collect u_collect (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .done_i        (done),
    .intr_enable_i (intr_enable),
    .pending_clr_i (pending_clr),
    .pending_o     (pending),
    .irq_o         (irq_o)
  );

endmodule

// ==== pwr_status_collect.sv ====
/* collects per-bank completion pulses into sticky pending flags and
   raises the interrupt for enabled ones */
`timescale 1ns/10ps

module pwr_status_collect (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  mem_pwr_pkg::bank_mask_t done_i,
  input  mem_pwr_pkg::bank_mask_t intr_enable_i,
  input  mem_pwr_pkg::bank_mask_t pending_clr_i,
  output mem_pwr_pkg::bank_mask_t pending_o,
  output logic                    irq_o
);

  mem_pwr_pkg::bank_mask_t pending_d;
  mem_pwr_pkg::bank_mask_t pending_q;
  logic irq_q;

  // a new completion wins over a clear in the same cycle
  assign pending_d = (pending_q & ~pending_clr_i) | done_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      irq_q <= 1'b0;
    end else begin
      pending_q <= pending_d;
      irq_q <= |(pending_d & intr_enable_i);
    end
  end

  assign pending_o = pending_q;
  assign irq_o = irq_q;

endmodule

// ==== src.f ====
mem_pwr_pkg.sv
mem_pwr_regs.sv
bank_pwr_fsm.sv
pwr_status_collect.sv
mem_pwr_top.sv
tb_clk_gen.sv
mem_pwr_chk.sv
tb_mem_pwr.sv

// ==== tb_clk_gen.sv ====
/* free-running testbench clock with a 4 ns period */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

endmodule

// ==== tb_mem_pwr.sv ====
/* testbench for the memory bank power manager; drives the AXI4-Lite port,
   models the bank power switches and checks state, pending flags and irq */
`timescale 1ns/10ps

module tb_mem_pwr;

  logic clk;
  logic rst;
  mem_pwr_pkg::axil_req_t axil_req;
  mem_pwr_pkg::axil_rsp_t axil_rsp;
  mem_pwr_pkg::bank_mask_t bank_ack;
  mem_pwr_pkg::bank_ctrl_t [mem_pwr_pkg::NUM_BANKS-1:0] bank_ctrl;
  logic irq;
  int unsigned sw_falls [mem_pwr_pkg::NUM_BANKS];
  bit [mem_pwr_pkg::NUM_BANKS-1:0] sw_prev;

  tb_clk_gen u_clk_gen (
    .clk_o (clk)
  );

  mem_pwr_top u_mem_pwr_top (
    .clk_i       (clk),
    .rst_i       (rst),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .bank_ack_i  (bank_ack),
    .bank_ctrl_o (bank_ctrl),
    .irq_o       (irq)
  );

  task automatic fail_now(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  // two bits per bank with bank 0 in the lowest bits
  function automatic mem_pwr_pkg::reg_data_t expected_state_word(
      input mem_pwr_pkg::bank_mask_t on_mask, input mem_pwr_pkg::bank_mask_t ret_mask);
    mem_pwr_pkg::reg_data_t word;
    word = '0;
    for (int b = 0; b < mem_pwr_pkg::NUM_BANKS; b++) begin
      if (on_mask[b]) begin
        word[2*b +: 2] = mem_pwr_pkg::BANK_ON;
      end else if (ret_mask[b]) begin
        word[2*b +: 2] = mem_pwr_pkg::BANK_RET;
      end else begin
        word[2*b +: 2] = mem_pwr_pkg::BANK_OFF;
      end
    end
    return word;
  endfunction

  // hold keeps bready low for that many cycles once bvalid is up
  task automatic write_reg(input mem_pwr_pkg::reg_addr_t addr,
                           input mem_pwr_pkg::reg_data_t data, input int unsigned hold,
                           output mem_pwr_pkg::axi_resp_t resp);
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr <= addr;
    axil_req.wvalid <= 1'b1;
    axil_req.wdata <= data;
    axil_req.wstrb <= '1;
    axil_req.bready <= (hold == 0);
    do @(posedge clk); while (!axil_rsp.awready);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid <= 1'b0;
    do @(posedge clk); while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    if (hold != 0) begin
      repeat (hold) @(posedge clk);
      axil_req.bready <= 1'b1;
      @(posedge clk);
    end
  endtask

  task automatic write_ok(input mem_pwr_pkg::reg_addr_t addr, input mem_pwr_pkg::reg_data_t data);
    mem_pwr_pkg::axi_resp_t resp;
    write_reg(addr, data, 0, resp);
    if (resp !== mem_pwr_pkg::RESP_OKAY) begin
      fail_now($sformatf("write to 0x%02h answered with resp %0d", addr, resp));
    end
  endtask

  task automatic read_reg(input mem_pwr_pkg::reg_addr_t addr,
                          output mem_pwr_pkg::reg_data_t data,
                          output mem_pwr_pkg::axi_resp_t resp);
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr <= addr;
    do @(posedge clk); while (!axil_rsp.arready);
    axil_req.arvalid <= 1'b0;
    do @(posedge clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
  endtask

  task automatic check_read(input mem_pwr_pkg::reg_addr_t addr,
                            input mem_pwr_pkg::reg_data_t exp, input string what);
    mem_pwr_pkg::reg_data_t data;
    mem_pwr_pkg::axi_resp_t resp;
    read_reg(addr, data, resp);
    if (resp !== mem_pwr_pkg::RESP_OKAY || data !== exp) begin
      fail_now($sformatf("%s read 0x%08h resp %0d, expected 0x%08h", what, data, resp, exp));
    end
  endtask

  // latency of the switches varies, so keep reading until it matches
  task automatic poll_reg(input mem_pwr_pkg::reg_addr_t addr, input mem_pwr_pkg::reg_data_t exp);
    mem_pwr_pkg::reg_data_t data;
    mem_pwr_pkg::axi_resp_t resp;
    do begin
      read_reg(addr, data, resp);
    end while (data !== exp || resp !== mem_pwr_pkg::RESP_OKAY);
  endtask

  task automatic check_irq(input logic exp, input string what);
    @(negedge clk);
    if (irq !== exp) begin
      fail_now($sformatf("irq_o is %b %s", irq, what));
    end
  endtask

  task automatic check_banks_off();
    mem_pwr_pkg::bank_ctrl_t exp;
    exp = '{pwr_sw: 1'b0, iso: 1'b1, rst: 1'b1, clk_en: 1'b0, retentive: 1'b0};
    @(negedge clk);
    for (int b = 0; b < mem_pwr_pkg::NUM_BANKS; b++) begin
      if (bank_ctrl[b] !== exp) begin
        fail_now($sformatf("bank %0d controls %b, expected %b", b, bank_ctrl[b], exp));
      end
    end
  endtask

  // each switch ack follows pwr_sw after 1 to 8 cycles
  initial begin : switch_model
    int unsigned delay [mem_pwr_pkg::NUM_BANKS];
    void'($urandom(82200));
    bank_ack = '0;
    wait (rst == 1'b0);
    forever begin
      @(negedge clk);
      for (int b = 0; b < mem_pwr_pkg::NUM_BANKS; b++) begin
        if (delay[b] == 0 && bank_ctrl[b].pwr_sw !== bank_ack[b]) begin
          delay[b] = $urandom_range(8, 1);
        end
      end
      @(posedge clk);
      for (int b = 0; b < mem_pwr_pkg::NUM_BANKS; b++) begin
        if (delay[b] != 0) begin
          delay[b]--;
          if (delay[b] == 0) begin
            bank_ack[b] <= !bank_ack[b];
          end
        end
      end
    end
  end

  always @(negedge clk) begin
    for (int b = 0; b < mem_pwr_pkg::NUM_BANKS; b++) begin
      if (sw_prev[b] && !bank_ctrl[b].pwr_sw) begin
        sw_falls[b]++;
      end
      sw_prev[b] = bank_ctrl[b].pwr_sw;
    end
  end

  always @(negedge clk) begin
    if (u_mem_pwr_top.u_chk.err_cnt != 0) begin
      $display("an assertion in the checker failed");
      $display("tests failed");
      $fatal(1, "stopped on an assertion failure");
    end
  end

  initial begin : watchdog
    int unsigned budget;
    // about 40 bus transfers and polls of up to 50 cycles each
    budget = 40 * 50;
    repeat (budget) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", budget);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    mem_pwr_pkg::axi_resp_t resp;
    mem_pwr_pkg::reg_data_t data;
    int unsigned falls_before [mem_pwr_pkg::NUM_BANKS];
    rst = 1'b1;
    axil_req = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    check_banks_off();
    check_irq(1'b0, "after reset");
    check_read(mem_pwr_pkg::REG_STATE, expected_state_word('0, '0), "state after reset");
    check_read(mem_pwr_pkg::REG_INTR_PENDING, 32'h0, "pending after reset");

    // read-back and unmapped offsets
    write_ok(mem_pwr_pkg::REG_INTR_ENABLE, 32'h5);
    check_read(mem_pwr_pkg::REG_INTR_ENABLE, 32'h5, "interrupt enable");
    write_ok(mem_pwr_pkg::REG_RETENTIVE, 32'hA);
    check_read(mem_pwr_pkg::REG_RETENTIVE, 32'hA, "retentive");
    write_ok(mem_pwr_pkg::REG_RETENTIVE, 32'h0);
    check_read(mem_pwr_pkg::REG_RETENTIVE, 32'h0, "retentive cleared");
    write_reg(5'h14, 32'hFFFF_FFFF, 0, resp);
    if (resp !== mem_pwr_pkg::RESP_SLVERR) begin
      fail_now($sformatf("write to offset 0x14 answered with resp %0d", resp));
    end
    read_reg(5'h1C, data, resp);
    if (resp !== mem_pwr_pkg::RESP_SLVERR || data !== 32'h0) begin
      fail_now($sformatf("read of offset 0x1C gave 0x%08h resp %0d", data, resp));
    end
    check_read(mem_pwr_pkg::REG_POWER_ON, 32'h0, "power on after unmapped write");

    // power-up of all banks and the interrupt
    write_ok(mem_pwr_pkg::REG_INTR_ENABLE, 32'h1);
    write_ok(mem_pwr_pkg::REG_POWER_ON, 32'hF);
    check_read(mem_pwr_pkg::REG_POWER_ON, 32'hF, "power on");
    poll_reg(mem_pwr_pkg::REG_STATE, expected_state_word(4'hF, 4'h0));
    check_read(mem_pwr_pkg::REG_INTR_PENDING, 32'hF, "pending after power-up");
    check_irq(1'b1, "with bank 0 pending and enabled");
    write_ok(mem_pwr_pkg::REG_INTR_PENDING, 32'h1);
    check_read(mem_pwr_pkg::REG_INTR_PENDING, 32'hE, "pending after clearing bank 0");
    check_irq(1'b0, "with only disabled bits pending");
    write_ok(mem_pwr_pkg::REG_INTR_PENDING, 32'hE);
    check_read(mem_pwr_pkg::REG_INTR_PENDING, 32'h0, "pending after clearing all");

    // retention of banks 0 and 1, then power-up again
    falls_before = sw_falls;
    write_ok(mem_pwr_pkg::REG_RETENTIVE, 32'h3);
    write_ok(mem_pwr_pkg::REG_POWER_ON, 32'hC);
    poll_reg(mem_pwr_pkg::REG_STATE, expected_state_word(4'hC, 4'h3));
    check_read(mem_pwr_pkg::REG_INTR_PENDING, 32'h3, "pending after retention");
    check_irq(1'b1, "after bank 0 entered retention");
    write_ok(mem_pwr_pkg::REG_POWER_ON, 32'hF);
    poll_reg(mem_pwr_pkg::REG_STATE, expected_state_word(4'hF, 4'h3));
    for (int b = 0; b < mem_pwr_pkg::NUM_BANKS; b++) begin
      if (sw_falls[b] != falls_before[b]) begin
        fail_now($sformatf("bank %0d pwr_sw dropped around retention", b));
      end
    end

    // retention left through a full power-down, then all banks off
    write_ok(mem_pwr_pkg::REG_INTR_PENDING, 32'hF);
    write_ok(mem_pwr_pkg::REG_RETENTIVE, 32'h1);
    write_ok(mem_pwr_pkg::REG_POWER_ON, 32'hE);
    poll_reg(mem_pwr_pkg::REG_STATE, expected_state_word(4'hE, 4'h1));
    write_ok(mem_pwr_pkg::REG_RETENTIVE, 32'h0);
    poll_reg(mem_pwr_pkg::REG_STATE, expected_state_word(4'hE, 4'h0));
    write_ok(mem_pwr_pkg::REG_POWER_ON, 32'h0);
    poll_reg(mem_pwr_pkg::REG_STATE, expected_state_word(4'h0, 4'h0));
    check_read(mem_pwr_pkg::REG_INTR_PENDING, 32'hF, "pending after power-down");
    check_banks_off();

    // write responses under back-pressure
    write_reg(mem_pwr_pkg::REG_INTR_ENABLE, 32'h3, 6, resp);
    if (resp !== mem_pwr_pkg::RESP_OKAY) begin
      fail_now($sformatf("held write answered with resp %0d", resp));
    end
    check_read(mem_pwr_pkg::REG_INTR_ENABLE, 32'h3, "enable after held write");
    write_reg(5'h18, 32'h1, 4, resp);
    if (resp !== mem_pwr_pkg::RESP_SLVERR) begin
      fail_now($sformatf("held write to offset 0x18 answered with resp %0d", resp));
    end

    // read response held with rready low
    axil_req.rready <= 1'b0;
    read_reg(mem_pwr_pkg::REG_INTR_ENABLE, data, resp);
    repeat (4) @(posedge clk);
    axil_req.rready <= 1'b1;
    @(posedge clk);
    if (resp !== mem_pwr_pkg::RESP_OKAY || data !== 32'h3) begin
      fail_now($sformatf("held read gave 0x%08h resp %0d, expected 0x00000003", data, resp));
    end

    @(negedge clk);
    if (u_mem_pwr_top.u_chk.err_cnt == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "checker reported assertion failures");
    end
  end

endmodule
